// File: common/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// ------------------------------------------------------------
// Bus widths
// ------------------------------------------------------------
`define DATA_W 8
`define ADDR_W 16

// Reset vector bytes in low then high order
`define RESET_VEC_LO 16'hFFFC
`define RESET_VEC_HI 16'hFFFD

// ------------------------------------------------------------
// Status register bit positions
// ------------------------------------------------------------
`define FLAG_N 7
`define FLAG_V 6
// Unused bit, always reads as one
`define FLAG_U 5
`define FLAG_Z 1
`define FLAG_C 0

`endif

// File: common/cpu_pkg.sv
package cpu_pkg;

`include "cpu_macros.svh"

  typedef logic [`DATA_W-1:0] data_t;
  typedef logic [`ADDR_W-1:0] addr_t;

  // ------------------------------------------------------------
  // Instruction sequencer states
  // ------------------------------------------------------------
  typedef enum logic [2:0] {
    RESET,
    VECTOR_1,
    VECTOR_2,
    FETCH,
    DECODE,
    ABS_1,
    ABS_2,
    HALT
  } cpu_state_e;

  // Supported opcodes with their real 6502 encodings
  typedef enum logic [7:0] {
    LDA_IMM = 8'hA9,
    LDX_IMM = 8'hA2,
    LDY_IMM = 8'hA0,
    CLC_IMP = 8'h18,
    SEC_IMP = 8'h38,
    CLV_IMP = 8'hB8,
    NOP_IMP = 8'hEA,
    LDA_ABS = 8'hAD,
    LDX_ABS = 8'hAE,
    LDY_ABS = 8'hAC,
    STA_ABS = 8'h8D,
    STX_ABS = 8'h8E,
    STY_ABS = 8'h8C,
    ADC_ABS = 8'h6D,
    SBC_ABS = 8'hED,
    AND_ABS = 8'h2D,
    ORA_ABS = 8'h0D,
    EOR_ABS = 8'h4D,
    CMP_ABS = 8'hCD,
    JMP_ABS = 8'h4C
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_e;

  // Where the bus address comes from this cycle
  typedef enum logic [2:0] {
    ADDR_PC,
    ADDR_PC1,
    ADDR_PC2,
    ADDR_OPERAND,
    ADDR_VEC_LO,
    ADDR_VEC_HI
  } addr_sel_e;

  typedef struct packed {
    addr_t address;
    data_t wr_data;
    logic  wr_enable;
  } mem_req_t;

  // Datapath steering for the current cycle
  typedef struct packed {
    logic       load_a;
    logic       load_x;
    logic       load_y;
    logic       src_mem;
    alu_op_e    alu_op;
    logic       set_nz;
    logic       set_c;
    logic       set_v;
    logic       flag_value;
    // 0 is A, 1 is X, 2 is Y
    logic [1:0] store_sel;
    logic       compare;
  } ctrl_t;

endpackage

// File: logic/alu.sv
`timescale 1ns/1ps

`include "cpu_macros.svh"

module alu import cpu_pkg::*; (
  input  alu_op_e op,
  input  data_t   a,
  input  data_t   b,
  input  logic    carry_in,
  output data_t   result,
  output logic    carry_out,
  output logic    overflow
);

  localparam int MSB = `DATA_W - 1;

  data_t            b_eff;
  logic [`DATA_W:0] sum;

  // Subtract adds the inverted operand and carry acts as not-borrow
  assign b_eff = (op == ALU_SUB) ? ~b : b;
  assign sum   = {1'b0, a} + {1'b0, b_eff} + {{`DATA_W{1'b0}}, carry_in};

  always_comb begin
    result    = sum[MSB:0];
    carry_out = 1'b0;
    overflow  = 1'b0;
    case (op)
      ALU_ADD,
      ALU_SUB: begin
        carry_out = sum[`DATA_W];
        // Same operand signs but result sign differs
        overflow  = (a[MSB] == b_eff[MSB]) && (sum[MSB] != a[MSB]);
      end
      ALU_AND: begin
        result = a & b;
      end
      ALU_OR: begin
        result = a | b;
      end
      ALU_XOR: begin
        result = a ^ b;
      end
      default: begin
        result = sum[MSB:0];
      end
    endcase
  end

endmodule

// File: logic/pc_unit.sv
`timescale 1ns/1ps

`include "cpu_macros.svh"

module pc_unit import cpu_pkg::*; (
  input  logic      clk,
  input  logic      resetn,
  input  data_t     rd_data,
  input  addr_sel_e addr_sel,
  input  logic [1:0] pc_step,
  input  logic      load_pc_vec_lo,
  input  logic      load_pc_vec_hi,
  input  logic      load_pc_jmp,
  input  logic      latch_lo,
  input  logic      latch_hi,
  output addr_t     address
);

  addr_t pc;
  data_t operand_lo;
  data_t operand_hi;

  // ------------------------------------------------------------
  // Program counter
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      pc <= '0;
    end else if (load_pc_vec_lo) begin
      pc[`DATA_W-1:0] <= rd_data;
    end else if (load_pc_vec_hi) begin
      pc[`ADDR_W-1:`DATA_W] <= rd_data;
    end else if (load_pc_jmp) begin
      // Target high byte is on the bus right now
      pc <= {rd_data, operand_lo};
    end else begin
      pc <= pc + addr_t'(pc_step);
    end
  end

  // Operand bytes of absolute instructions
  always_ff @(posedge clk) begin
    if (latch_lo) begin
      operand_lo <= rd_data;
    end
    if (latch_hi) begin
      operand_hi <= rd_data;
    end
  end

  // ------------------------------------------------------------
  // Bus address select
  // ------------------------------------------------------------
  always_comb begin
    case (addr_sel)
      ADDR_PC:      address = pc;
      ADDR_PC1:     address = pc + addr_t'(1);
      ADDR_PC2:     address = pc + addr_t'(2);
      ADDR_OPERAND: address = {operand_hi, operand_lo};
      ADDR_VEC_LO:  address = `RESET_VEC_LO;
      ADDR_VEC_HI:  address = `RESET_VEC_HI;
      default:      address = pc;
    endcase
  end

endmodule

// File: logic/reg_file.sv
`timescale 1ns/1ps

`include "cpu_macros.svh"

module reg_file import cpu_pkg::*; (
  input  logic  clk,
  input  logic  resetn,
  input  ctrl_t ctrl,
  input  data_t rd_data,
  input  data_t alu_result,
  input  logic  alu_carry,
  input  logic  alu_overflow,
  output data_t alu_a,
  output logic  carry,
  output data_t wr_data
);

  data_t a_reg;
  data_t x_reg;
  data_t y_reg;
  data_t p_reg;

  data_t load_value;
  logic  alu_flags;

  // Value seen by loads and by the N and Z flags
  assign load_value = ctrl.src_mem ? rd_data : alu_result;

  // C and V come from the ALU for arithmetic and compare and otherwise from decode
  assign alu_flags = ctrl.compare | (ctrl.load_a & ~ctrl.src_mem);

  assign alu_a = a_reg;

  // Compare always subtracts without borrow
  assign carry = ctrl.compare ? 1'b1 : p_reg[`FLAG_C];

  // ------------------------------------------------------------
  // Registers
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (ctrl.load_a) begin
      a_reg <= load_value;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      x_reg <= '0;
      y_reg <= '0;
    end else begin
      if (ctrl.load_x) begin
        x_reg <= load_value;
      end
      if (ctrl.load_y) begin
        y_reg <= load_value;
      end
    end
  end

  // Status register
  always_ff @(posedge clk) begin
    if (!resetn) begin
      p_reg <= '0;
      p_reg[`FLAG_U] <= 1'b1;
    end else begin
      if (ctrl.set_nz) begin
        p_reg[`FLAG_N] <= load_value[`DATA_W-1];
        p_reg[`FLAG_Z] <= (load_value == '0);
      end
      if (ctrl.set_c) begin
        p_reg[`FLAG_C] <= alu_flags ? alu_carry : ctrl.flag_value;
      end
      if (ctrl.set_v) begin
        p_reg[`FLAG_V] <= alu_flags ? alu_overflow : ctrl.flag_value;
      end
      p_reg[`FLAG_U] <= 1'b1;
    end
  end

  // Store data
  always_comb begin
    case (ctrl.store_sel)
      2'd1:    wr_data = x_reg;
      2'd2:    wr_data = y_reg;
      default: wr_data = a_reg;
    endcase
  end

  // Bit 5 holds through every instruction
  a_flag_u_set: assert property (
    @(posedge clk) disable iff (!resetn) p_reg[`FLAG_U]
  );

endmodule

// File: logic/cpu_fsm.sv
`timescale 1ns/1ps

module cpu_fsm import cpu_pkg::*; (
  input  logic       clk,
  input  logic       resetn,
  input  data_t      rd_data,
  output ctrl_t      ctrl,
  output addr_sel_e  addr_sel,
  output logic       load_ir,
  output logic [1:0] pc_step,
  output logic       load_pc_vec_lo,
  output logic       load_pc_vec_hi,
  output logic       load_pc_jmp,
  output logic       latch_lo,
  output logic       latch_hi,
  output logic       wr_enable,
  output logic       halted
);

  cpu_state_e state;
  cpu_state_e next_state;
  opcode_e    ir;

  // Decoded instruction
  ctrl_t      op_ctrl;
  logic       is_short;
  logic       is_abs;
  logic       is_store;
  logic       is_jmp;
  logic [1:0] short_step;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= RESET;
    end else begin
      state <= next_state;
    end
  end

  always_ff @(posedge clk) begin
    if (load_ir) begin
      ir <= opcode_e'(rd_data);
    end
  end

  // ------------------------------------------------------------
  // Opcode decode
  // ------------------------------------------------------------
  always_comb begin
    op_ctrl    = '0;
    is_short   = 1'b0;
    is_abs     = 1'b0;
    is_store   = 1'b0;
    is_jmp     = 1'b0;
    short_step = 2'd1;
    case (ir)
      // Two byte immediate loads
      LDA_IMM, LDX_IMM, LDY_IMM: begin
        is_short       = 1'b1;
        short_step     = 2'd2;
        op_ctrl.src_mem = 1'b1;
        op_ctrl.set_nz = 1'b1;
        op_ctrl.load_a = (ir == LDA_IMM);
        op_ctrl.load_x = (ir == LDX_IMM);
        op_ctrl.load_y = (ir == LDY_IMM);
      end
      CLC_IMP, SEC_IMP: begin
        is_short           = 1'b1;
        op_ctrl.set_c      = 1'b1;
        op_ctrl.flag_value = (ir == SEC_IMP);
      end
      CLV_IMP: begin
        is_short      = 1'b1;
        op_ctrl.set_v = 1'b1;
      end
      NOP_IMP: begin
        is_short = 1'b1;
      end
      LDA_ABS, LDX_ABS, LDY_ABS: begin
        is_abs          = 1'b1;
        op_ctrl.src_mem = 1'b1;
        op_ctrl.set_nz  = 1'b1;
        op_ctrl.load_a  = (ir == LDA_ABS);
        op_ctrl.load_x  = (ir == LDX_ABS);
        op_ctrl.load_y  = (ir == LDY_ABS);
      end
      STA_ABS, STX_ABS, STY_ABS: begin
        is_abs   = 1'b1;
        is_store = 1'b1;
        if (ir == STX_ABS) begin
          op_ctrl.store_sel = 2'd1;
        end else if (ir == STY_ABS) begin
          op_ctrl.store_sel = 2'd2;
        end
      end
      ADC_ABS, SBC_ABS: begin
        is_abs         = 1'b1;
        op_ctrl.load_a = 1'b1;
        op_ctrl.alu_op = (ir == SBC_ABS) ? ALU_SUB : ALU_ADD;
        op_ctrl.set_nz = 1'b1;
        op_ctrl.set_c  = 1'b1;
        op_ctrl.set_v  = 1'b1;
      end
      AND_ABS, ORA_ABS, EOR_ABS: begin
        is_abs         = 1'b1;
        op_ctrl.load_a = 1'b1;
        op_ctrl.set_nz = 1'b1;
        if (ir == AND_ABS) begin
          op_ctrl.alu_op = ALU_AND;
        end else if (ir == ORA_ABS) begin
          op_ctrl.alu_op = ALU_OR;
        end else begin
          op_ctrl.alu_op = ALU_XOR;
        end
      end
      // Flags from A minus operand while A stays untouched
      CMP_ABS: begin
        is_abs          = 1'b1;
        op_ctrl.compare = 1'b1;
        op_ctrl.alu_op  = ALU_SUB;
        op_ctrl.set_nz  = 1'b1;
        op_ctrl.set_c   = 1'b1;
      end
      JMP_ABS: begin
        is_abs = 1'b1;
        is_jmp = 1'b1;
      end
      default: begin
        is_abs = 1'b0;
      end
    endcase
  end

  // ------------------------------------------------------------
  // Next state
  // ------------------------------------------------------------
  always_comb begin
    case (state)
      RESET:    next_state = VECTOR_1;
      VECTOR_1: next_state = VECTOR_2;
      VECTOR_2: next_state = FETCH;
      FETCH:    next_state = DECODE;
      DECODE: begin
        if (is_short) begin
          next_state = FETCH;
        end else if (is_abs) begin
          next_state = ABS_1;
        end else begin
          next_state = HALT;
        end
      end
      ABS_1:    next_state = is_jmp ? FETCH : ABS_2;
      ABS_2:    next_state = FETCH;
      default:  next_state = HALT;
    endcase
  end

  // ------------------------------------------------------------
  // Per state outputs
  // ------------------------------------------------------------
  always_comb begin
    ctrl           = '0;
    addr_sel       = ADDR_PC;
    load_ir        = 1'b0;
    pc_step        = 2'd0;
    load_pc_vec_lo = 1'b0;
    load_pc_vec_hi = 1'b0;
    load_pc_jmp    = 1'b0;
    latch_lo       = 1'b0;
    latch_hi       = 1'b0;
    wr_enable      = 1'b0;
    case (state)
      RESET: begin
        addr_sel = ADDR_VEC_LO;
      end
      VECTOR_1: begin
        addr_sel       = ADDR_VEC_LO;
        load_pc_vec_lo = 1'b1;
      end
      VECTOR_2: begin
        addr_sel       = ADDR_VEC_HI;
        load_pc_vec_hi = 1'b1;
      end
      FETCH: begin
        load_ir = 1'b1;
      end
      // Short instructions finish here
      DECODE: begin
        addr_sel = ADDR_PC1;
        latch_lo = 1'b1;
        if (is_short) begin
          pc_step = short_step;
          ctrl    = op_ctrl;
        end
      end
      ABS_1: begin
        addr_sel    = ADDR_PC2;
        latch_hi    = 1'b1;
        load_pc_jmp = is_jmp;
      end
      ABS_2: begin
        addr_sel  = ADDR_OPERAND;
        pc_step   = 2'd3;
        ctrl      = op_ctrl;
        wr_enable = is_store;
      end
      default: begin
        addr_sel = ADDR_PC;
      end
    endcase
  end

  assign halted = (state == HALT);

  // A write only ever ends a four cycle absolute sequence
  a_write_in_abs2: assert property (
    @(posedge clk) disable iff (!resetn)
    wr_enable |-> (state == ABS_2) && ($past(state, 2) == DECODE)
  );

  a_halt_sticky: assert property (
    @(posedge clk) disable iff (!resetn)
    (state == HALT) |=> (state == HALT)
  );

endmodule

// File: logic/cpu_core.sv
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; (
  input  logic     clk,
  input  logic     resetn,
  input  data_t    rd_data,
  output mem_req_t mem_req,
  output logic     halted
);

  ctrl_t      ctrl;
  addr_sel_e  addr_sel;
  logic [1:0] pc_step;
  logic       load_pc_vec_lo;
  logic       load_pc_vec_hi;
  logic       load_pc_jmp;
  logic       latch_lo;
  logic       latch_hi;

  data_t      alu_a;
  data_t      alu_result;
  logic       alu_carry_in;
  logic       alu_carry;
  logic       alu_overflow;

  // ------------------------------------------------------------
  // Sequencer
  // ------------------------------------------------------------
  cpu_fsm fsm0 (
    .clk            (clk),
    .resetn         (resetn),
    .rd_data        (rd_data),
    .ctrl           (ctrl),
    .addr_sel       (addr_sel),
    .load_ir        (),
    .pc_step        (pc_step),
    .load_pc_vec_lo (load_pc_vec_lo),
    .load_pc_vec_hi (load_pc_vec_hi),
    .load_pc_jmp    (load_pc_jmp),
    .latch_lo       (latch_lo),
    .latch_hi       (latch_hi),
    .wr_enable      (mem_req.wr_enable),
    .halted         (halted)
  );

  pc_unit pc0 (
    .clk            (clk),
    .resetn         (resetn),
    .rd_data        (rd_data),
    .addr_sel       (addr_sel),
    .pc_step        (pc_step),
    .load_pc_vec_lo (load_pc_vec_lo),
    .load_pc_vec_hi (load_pc_vec_hi),
    .load_pc_jmp    (load_pc_jmp),
    .latch_lo       (latch_lo),
    .latch_hi       (latch_hi),
    .address        (mem_req.address)
  );

  // ------------------------------------------------------------
  // Datapath
  // ------------------------------------------------------------
  reg_file regs0 (
    .clk          (clk),
    .resetn       (resetn),
    .ctrl         (ctrl),
    .rd_data      (rd_data),
    .alu_result   (alu_result),
    .alu_carry    (alu_carry),
    .alu_overflow (alu_overflow),
    .alu_a        (alu_a),
    .carry        (alu_carry_in),
    .wr_data      (mem_req.wr_data)
  );

  // Second operand is always the byte on the bus
  alu alu0 (
    .op        (ctrl.alu_op),
    .a         (alu_a),
    .b         (rd_data),
    .carry_in  (alu_carry_in),
    .result    (alu_result),
    .carry_out (alu_carry),
    .overflow  (alu_overflow)
  );

endmodule

// File: test/tb_cpu_core.sv
`timescale 1ns/1ps

`include "cpu_macros.svh"

module tb_cpu_core import cpu_pkg::*; ();

  // Reset, vector fetch and the alignment edge before a test
  localparam int    RESET_CYCLES     = 6;
  localparam int    POST_HALT_CYCLES = 4;
  localparam addr_t ORIGIN           = 16'h0400;
  localparam addr_t ZERO_ADDR        = 16'h03F0;
  localparam data_t HALT_OP          = 8'h02;

  logic     clk = 1'b0;
  logic     resetn = 1'b0;
  data_t    rd_data;
  mem_req_t mem_req;
  logic     halted;

  data_t mem [0:65535];

  addr_t wr_addr_log[$];
  data_t wr_data_log[$];
  addr_t exp_addr[$];
  data_t exp_data[$];

  addr_t  prog_ptr;
  int     prog_cycles;
  int     log_base;
  int     test_err_base;
  int     cycle_count = 0;
  int     cycle_limit = 0;
  int     error_count = 0;
  int     check_count = 0;
  int     test_count = 0;
  integer seed;

  cpu_core dut0 (
    .clk     (clk),
    .resetn  (resetn),
    .rd_data (rd_data),
    .mem_req (mem_req),
    .halted  (halted)
  );

  always #5 clk = ~clk;

  // ------------------------------------------------------------
  // Memory model with combinational read and logged writes
  // ------------------------------------------------------------
  assign rd_data = mem[mem_req.address];

  always @(posedge clk) begin
    if (mem_req.wr_enable) begin
      mem[mem_req.address] <= mem_req.wr_data;
      wr_addr_log.push_back(mem_req.address);
      wr_data_log.push_back(mem_req.wr_data);
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: the run went past its limit of %0d cycles", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic data_t fill_value(input addr_t a);
    return a[15:8] ^ a[7:0] ^ 8'h5A;
  endfunction

  function automatic data_t rand_byte();
    logic [31:0] r;
    r = $random(seed);
    return r[7:0];
  endfunction

  // ------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------
  task automatic check_data(input string name, input data_t got, input data_t exp);
    check_count++;
    if (got !== exp) begin
      $display("ERR %s: got 0x%02h, expected 0x%02h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    check_count++;
    if (got !== exp) begin
      $display("ERR %s: got 0x%04h, expected 0x%04h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_halted(input logic seen, input int cycles, input int expected);
    check_count++;
    if (!seen) begin
      $display("Halt never came within %0d cycles after reset", cycles);
      error_count++;
    end else if (cycles < expected) begin
      $display("Halt came early after %0d cycles, expected %0d", cycles, expected);
      error_count++;
    end else if (cycles > expected) begin
      $display("Halt came late after %0d cycles, expected %0d", cycles, expected);
      error_count++;
    end
  endtask

  task automatic check_writes();
    int n;
    n = wr_addr_log.size() - log_base;
    check_count++;
    if (n != exp_addr.size()) begin
      $display("Wrong number of writes: saw %0d, expected %0d", n, exp_addr.size());
      error_count++;
    end else begin
      for (int i = 0; i < n; i++) begin
        check_addr($sformatf("address[%0d]", i), wr_addr_log[log_base + i], exp_addr[i]);
        check_data($sformatf("wr_data[%0d]", i), wr_data_log[log_base + i], exp_data[i]);
      end
    end
  endtask

  // ------------------------------------------------------------
  // Program building
  // ------------------------------------------------------------
  task automatic start_program();
    addr_t a;
    for (int i = 0; i < 65536; i++) begin
      a = i[15:0];
      mem[a] <= fill_value(a);
    end
    mem[`RESET_VEC_LO] <= ORIGIN[7:0];
    mem[`RESET_VEC_HI] <= ORIGIN[15:8];
    mem[ZERO_ADDR] <= 8'h00;
    prog_ptr = ORIGIN;
    prog_cycles = 0;
    exp_addr.delete();
    exp_data.delete();
    log_base = wr_addr_log.size();
    test_err_base = error_count;
  endtask

  task automatic emit_byte(input data_t b);
    mem[prog_ptr] <= b;
    prog_ptr = prog_ptr + 16'd1;
  endtask

  task automatic emit_imp(input opcode_e op);
    emit_byte(op);
    prog_cycles += 2;
  endtask

  task automatic emit_imm(input opcode_e op, input data_t v);
    emit_byte(op);
    emit_byte(v);
    prog_cycles += 2;
  endtask

  task automatic emit_abs(input opcode_e op, input addr_t a);
    emit_byte(op);
    emit_byte(a[7:0]);
    emit_byte(a[15:8]);
    prog_cycles += (op == JMP_ABS) ? 3 : 4;
  endtask

  // Unknown opcode that halts after fetch and decode
  task automatic emit_halt();
    emit_byte(HALT_OP);
    prog_cycles += 2;
  endtask

  task automatic expect_write(input addr_t a, input data_t v);
    exp_addr.push_back(a);
    exp_data.push_back(v);
  endtask

  task automatic run_program();
    int expected;
    int cycles;
    expected = 3 + prog_cycles;
    cycle_limit += 2 * (prog_cycles + RESET_CYCLES + POST_HALT_CYCLES);
    @(negedge clk);
    resetn = 1'b0;
    repeat (2) @(negedge clk);
    resetn = 1'b1;
    cycles = 0;
    while (!halted && cycles < 2 * expected) begin
      @(negedge clk);
      cycles++;
    end
    check_halted(halted, cycles, expected);
    repeat (POST_HALT_CYCLES) @(negedge clk);
    check_count++;
    if (!halted) begin
      $display("Halted dropped before the next reset");
      error_count++;
    end
    check_writes();
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = error_count - test_err_base;
    test_count++;
    if (errs == 0) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, errs);
    end
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------
  task automatic test_reset_loads();
    data_t va;
    data_t vx;
    data_t vy;
    start_program();
    va = rand_byte();
    vx = rand_byte();
    vy = rand_byte();
    mem[16'h0300] <= vx;
    emit_imm(LDA_IMM, va);
    emit_abs(LDX_ABS, 16'h0300);
    emit_imm(LDY_IMM, vy);
    emit_abs(STA_ABS, 16'h0200);
    emit_abs(STX_ABS, 16'h0201);
    emit_abs(STY_ABS, 16'h0202);
    emit_halt();
    expect_write(16'h0200, va);
    expect_write(16'h0201, vx);
    expect_write(16'h0202, vy);
    run_program();
    finish_test("reset_loads");
  endtask

  task automatic test_arith();
    data_t      a1;
    data_t      b1;
    data_t      a2;
    data_t      b2;
    logic [8:0] sum;
    start_program();
    a1 = rand_byte();
    b1 = rand_byte();
    a2 = rand_byte();
    b2 = rand_byte();
    mem[16'h0300] <= b1;
    mem[16'h0301] <= b2;
    // Carry set first so that CLC has something to clear
    emit_imp(SEC_IMP);
    emit_imp(CLC_IMP);
    emit_imm(LDA_IMM, a1);
    emit_abs(ADC_ABS, 16'h0300);
    emit_abs(STA_ABS, 16'h0210);
    // Zero plus zero plus carry exposes C
    emit_imm(LDA_IMM, 8'h00);
    emit_abs(ADC_ABS, ZERO_ADDR);
    emit_abs(STA_ABS, 16'h0211);
    emit_imp(SEC_IMP);
    emit_imm(LDA_IMM, a2);
    emit_abs(SBC_ABS, 16'h0301);
    emit_abs(STA_ABS, 16'h0212);
    emit_imm(LDA_IMM, 8'h00);
    emit_abs(ADC_ABS, ZERO_ADDR);
    emit_abs(STA_ABS, 16'h0213);
    emit_halt();
    sum = {1'b0, a1} + {1'b0, b1};
    expect_write(16'h0210, sum[7:0]);
    expect_write(16'h0211, {7'd0, sum[8]});
    expect_write(16'h0212, a2 - b2);
    // No borrow when a2 is not below b2
    expect_write(16'h0213, {7'd0, a2 >= b2});
    run_program();
    finish_test("arith");
  endtask

  task automatic test_logic();
    data_t a;
    data_t b;
    start_program();
    a = rand_byte();
    b = rand_byte();
    mem[16'h0300] <= b;
    emit_imm(LDA_IMM, a);
    emit_abs(AND_ABS, 16'h0300);
    emit_abs(STA_ABS, 16'h0218);
    emit_imm(LDA_IMM, a);
    emit_abs(ORA_ABS, 16'h0300);
    emit_abs(STA_ABS, 16'h0219);
    emit_imm(LDA_IMM, a);
    emit_abs(EOR_ABS, 16'h0300);
    emit_abs(STA_ABS, 16'h021A);
    emit_halt();
    expect_write(16'h0218, a & b);
    expect_write(16'h0219, a | b);
    expect_write(16'h021A, a ^ b);
    run_program();
    finish_test("logic");
  endtask

  // Stores A after CMP and CLV and then C through an ADC of zero
  task automatic emit_compare(input data_t a, input data_t b, input addr_t b_addr,
                              input addr_t out);
    mem[b_addr] <= b;
    emit_imm(LDA_IMM, a);
    emit_abs(CMP_ABS, b_addr);
    emit_imp(CLV_IMP);
    emit_abs(STA_ABS, out);
    emit_imm(LDA_IMM, 8'h00);
    emit_abs(ADC_ABS, ZERO_ADDR);
    emit_abs(STA_ABS, out + 16'd1);
    expect_write(out, a);
    expect_write(out + 16'd1, {7'd0, a >= b});
  endtask

  task automatic test_compare();
    data_t a;
    data_t b;
    start_program();
    a = rand_byte();
    b = rand_byte();
    emit_compare(a, b, 16'h0300, 16'h0220);
    emit_compare(a, a, 16'h0301, 16'h0222);
    emit_compare(8'h10, 8'h80, 16'h0302, 16'h0224);
    emit_halt();
    run_program();
    finish_test("compare");
  endtask

  task automatic test_jump();
    data_t v;
    data_t w;
    int    kept;
    addr_t target;
    start_program();
    v = rand_byte();
    w = rand_byte();
    target = 16'h0480;
    emit_imm(LDA_IMM, v);
    emit_abs(JMP_ABS, target);
    // Skipped block whose cycles never run
    kept = prog_cycles;
    emit_abs(STA_ABS, 16'h0230);
    emit_abs(STX_ABS, 16'h0231);
    emit_abs(STY_ABS, 16'h0232);
    prog_cycles = kept;
    prog_ptr = target;
    emit_imp(NOP_IMP);
    emit_abs(STA_ABS, 16'h0233);
    emit_imm(LDX_IMM, w);
    emit_abs(STX_ABS, 16'h0234);
    emit_halt();
    expect_write(16'h0233, v);
    expect_write(16'h0234, w);
    run_program();
    check_data("mem[0230]", mem[16'h0230], fill_value(16'h0230));
    check_data("mem[0232]", mem[16'h0232], fill_value(16'h0232));
    finish_test("jump");
  endtask

  task automatic test_halt();
    data_t v;
    int    kept;
    start_program();
    v = rand_byte();
    emit_imm(LDA_IMM, v);
    emit_abs(STA_ABS, 16'h0240);
    emit_halt();
    kept = prog_cycles;
    emit_abs(STA_ABS, 16'h0241);
    emit_abs(STA_ABS, 16'h0242);
    prog_cycles = kept;
    expect_write(16'h0240, v);
    run_program();
    check_data("mem[0241]", mem[16'h0241], fill_value(16'h0241));
    check_data("mem[0242]", mem[16'h0242], fill_value(16'h0242));
    finish_test("halt");
  endtask

  initial begin
    seed = 32'hc7cf;
    test_reset_loads();
    test_arith();
    test_logic();
    test_compare();
    test_jump();
    test_halt();
    $display("Tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: cpu_core.f
+incdir+common
common/cpu_pkg.sv
logic/alu.sv
logic/pc_unit.sv
logic/reg_file.sv
logic/cpu_fsm.sv
logic/cpu_core.sv
test/tb_cpu_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f cpu_core.f --top-module tb_cpu_core -o sim_cpu_core
./obj_dir/sim_cpu_core > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
  echo "Run failed"
  exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
  echo "Run ended without a result"
  exit 1
fi
echo "Run passed"
